// ==== vlog.f ====
+incdir+common
+incdir+verification
common/gps_board_pkg.sv
display/seg7_encoder.sv
display/display_control.sv
src/sample_strobe_gen.sv
src/ready_stretcher.sv
src/gps_board_top.sv
verification/gps_board_tb.sv

// ==== Bender.yml ====
package:
  name: gps_board

sources:
  - include_dirs:
      - common
    files:
      - common/gps_board_pkg.sv
      - display/seg7_encoder.sv
      - display/display_control.sv
      - src/sample_strobe_gen.sv
      - src/ready_stretcher.sv
      - src/gps_board_top.sv

  - target: test
    include_dirs:
      - common
      - verification
    files:
      - verification/gps_board_tb.sv

// ==== verification/gps_board_model.svh ====
`ifndef GPS_BOARD_MODEL_SVH
`define GPS_BOARD_MODEL_SVH

// Hex glyphs with lit segments as ones, bit 0 is segment a
localparam logic [6:0] glyph_on [16] = '{
   7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
   7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

int unsigned edge_cnt;     // Edges since reset release
int unsigned step_due [$]; // Edges that owe a step strobe
logic        key_level;    // Key level at the previous edge
int unsigned ready_age;    // Edges since the last ready pulse
logic        flag_prev;    // Stretched flag after the previous edge
logic        exp_stb;
ledr_t       exp_ledr;
ledg_t       exp_ledg;
seg7_t       exp_hex [`GPS_NUM_DIGITS];
int unsigned step_cnt;     // Step strobes not hidden by the divider
int unsigned cs_views;
int unsigned value_views;

function automatic seg7_t glyph_low(nibble_t n);
   return ~glyph_on[n];
endfunction

task automatic predict_strobe();
   if (reset_i) begin
      edge_cnt  = 0;
      key_level = 1'b1;
      exp_stb   = 1'b0;
      step_due.delete();
   end else begin
      edge_cnt++;
      if (key_level && !step_key_n_i) begin
         step_due.push_back(edge_cnt + 3); // Press shows up three edges later
      end
      key_level = step_key_n_i;
      exp_stb   = (edge_cnt % (`GPS_SAMPLE_DIV_RELOAD + 1) == 0);
      if (step_due.size() > 0 && step_due[0] == edge_cnt) begin
         step_due.delete(0);
         if (!exp_stb) begin
            step_cnt++;
         end
         exp_stb = 1'b1; // Merges with a divider strobe
      end
   end
endtask

// LEDG[0] trails the stretched flag by one register
task automatic predict_ready(output logic led_bit);
   led_bit = flag_prev;
   if (reset_i) begin
      led_bit   = 1'b0;
      ready_age = 100;
      flag_prev = 1'b0;
   end else begin
      if (tracking_ready_i) begin
         ready_age = 0; // Retrigger restarts the hold
      end else if (ready_age < 100) begin
         ready_age++;
      end
      flag_prev = (ready_age <= `GPS_READY_HOLD);
   end
endtask

task automatic predict_display(input logic led_bit);
   acc_t        sel;
   logic [15:0] low_view;
   foreach (exp_hex[d]) exp_hex[d] = '1; // Dark unless enabled below
   if (reset_i) begin
      exp_ledr = '0;
      exp_ledg = '0;
   end else begin
      sel = sw_i[17] ? (sw_i[16] ? accum_q_i : accum_i_i) :
                       (sw_i[16] ? prompt_q_i : prompt_i_i);
      if (sw_i[14]) begin
         exp_ledr = ledr_t'(words_available_i);
      end else if (sw_i[13]) begin
         exp_ledr = ledr_t'(track_count_i);
      end else if (sw_i[12]) begin
         exp_ledr = sw_i[11] ? ledr_t'(good_pkt_count_i) : ledr_t'(pkt_count_i);
      end else begin
         exp_ledr = ledr_t'(sel);
      end
      exp_ledg = {link_status_i, sw_i[10] ? carrier_q_i : carrier_i_i,
                  sample_data_i, sample_valid_i, led_bit};
      if (sw_i[15]) begin
         low_view = {1'b0, code_shift_i};
         cs_views++;
      end else begin
         low_view   = sel[15:0];
         exp_hex[4] = glyph_low({2'b00, sel[17:16]});
         value_views++;
      end
      for (int d = 0; d < 4; d++) begin
         exp_hex[d] = glyph_low(low_view[4*d +: 4]);
      end
   end
endtask

`endif

// ==== verification/gps_board_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gps_board_defs.svh"

module gps_board_tb;
   import gps_board_pkg::*;

   logic                 clk_16_8;
   logic                 reset_i;
   logic [`GPS_SW_W-1:0] sw_i;
   logic                 step_key_n_i;
   logic                 tracking_ready_i;
   acc_t                 prompt_i_i;
   acc_t                 prompt_q_i;
   acc_t                 accum_i_i;
   acc_t                 accum_q_i;
   code_shift_t          code_shift_i;
   pkt_cnt_t             words_available_i;
   pkt_cnt_t             pkt_count_i;
   pkt_cnt_t             good_pkt_count_i;
   track_cnt_t           track_count_i;
   carrier_t             carrier_i_i;
   carrier_t             carrier_q_i;
   sample_t              sample_data_i;
   logic                 sample_valid_i;
   logic                 link_status_i;
   logic                 sample_stb_o;
   ledr_t                ledr_o;
   ledg_t                ledg_o;
   seg7_t                hex_out [`GPS_NUM_DIGITS];
   logic [31:0]          rng_state;
   logic                 key_test;    // Step key presses enabled
   int unsigned          key_left;    // Cycles until the key changes
   logic                 model_valid;
   logic                 ready_led;
   int unsigned          stb_errors;
   int unsigned          ready_errors;
   int unsigned          led_errors;
   int unsigned          hex_errors;
   int unsigned          other_errors;

   `include "gps_board_model.svh"

   gps_board_top i_dut (
      .clk_16_8 (clk_16_8), .reset_i (reset_i), .sw_i (sw_i),
      .step_key_n_i (step_key_n_i), .tracking_ready_i (tracking_ready_i),
      .prompt_i_i (prompt_i_i), .prompt_q_i (prompt_q_i),
      .accum_i_i (accum_i_i), .accum_q_i (accum_q_i), .code_shift_i (code_shift_i),
      .words_available_i (words_available_i), .pkt_count_i (pkt_count_i),
      .good_pkt_count_i (good_pkt_count_i), .track_count_i (track_count_i),
      .carrier_i_i (carrier_i_i), .carrier_q_i (carrier_q_i),
      .sample_data_i (sample_data_i), .sample_valid_i (sample_valid_i),
      .link_status_i (link_status_i), .sample_stb_o (sample_stb_o),
      .ledr_o (ledr_o), .ledg_o (ledg_o),
      .hex0_o (hex_out[0]), .hex1_o (hex_out[1]), .hex2_o (hex_out[2]),
      .hex3_o (hex_out[3]), .hex4_o (hex_out[4]), .hex5_o (hex_out[5]),
      .hex6_o (hex_out[6]), .hex7_o (hex_out[7])
   );

   always #2 clk_16_8 = ~clk_16_8;

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // Model sees the same inputs as the DUT at each rising edge
   always @(posedge clk_16_8) begin
      predict_ready(ready_led);
      predict_display(ready_led);
      predict_strobe();
      model_valid = 1'b1;
   end

   always @(negedge clk_16_8) begin
      if (model_valid) begin
         if (sample_stb_o !== exp_stb) begin
            $display("ERROR sample_stb_o expected 0x%h got 0x%h at %0t", exp_stb, sample_stb_o,
                     $time);
            stb_errors++;
         end
         if (ledg_o[0] !== exp_ledg[0]) begin
            $display("ERROR ledg_o[0] expected 0x%h got 0x%h at %0t", exp_ledg[0], ledg_o[0],
                     $time);
            ready_errors++;
         end
         if (ledr_o !== exp_ledr || ledg_o[8:1] !== exp_ledg[8:1]) begin
            $display("ERROR ledr_o expected 0x%h got 0x%h, ledg_o expected 0x%h got 0x%h",
                     exp_ledr, ledr_o, exp_ledg, ledg_o);
            led_errors++;
         end
         for (int d = 0; d < `GPS_NUM_DIGITS; d++) begin
            if (hex_out[d] !== exp_hex[d]) begin
               $display("ERROR hex%0d_o expected 0x%h got 0x%h at %0t", d, exp_hex[d],
                        hex_out[d], $time);
               hex_errors++;
            end
         end
      end
   end

   task automatic drive_inputs();
      logic [31:0] r [5];
      foreach (r[i]) r[i] = next_rand();
      sw_i              = r[0][17:0];
      track_count_i     = r[0][21:18];
      carrier_i_i       = r[0][24:22];
      carrier_q_i       = r[0][27:25];
      tracking_ready_i  = (r[0][31:28] == 4'h0); // About one pulse in 16 cycles
      prompt_i_i        = r[1][17:0];
      code_shift_i      = r[1][31:17];
      prompt_q_i        = r[2][17:0];
      words_available_i = r[2][26:18];
      sample_data_i     = r[2][29:27];
      sample_valid_i    = r[2][30];
      link_status_i     = r[2][31];
      accum_i_i         = r[3][17:0];
      pkt_count_i       = r[3][26:18];
      accum_q_i         = r[4][17:0];
      good_pkt_count_i  = r[4][26:18];
      if (key_test && key_left > 0) begin
         key_left--;
      end else if (key_test) begin
         step_key_n_i = ~step_key_n_i;
         key_left     = step_key_n_i ? 40 + r[4][31:26] : 4 + r[3][28:27]; // Gap or hold
      end
   endtask

   task automatic wait_strobe(output int unsigned cycles);
      logic seen;
      seen   = 1'b0;
      cycles = 0;
      while (!seen && cycles < 400) begin
         @(negedge clk_16_8);
         cycles++;
         seen = sample_stb_o;
         drive_inputs();
      end
      if (!seen) begin
         $display("Timeout: no sample strobe appeared within 400 cycles");
         other_errors++;
      end
   endtask

   initial begin
      int unsigned interval;
      clk_16_8 = 1'b0;
      reset_i = 1'b1;
      sw_i = '0;
      step_key_n_i = 1'b1;
      tracking_ready_i = 1'b0;
      {prompt_i_i, prompt_q_i, accum_i_i, accum_q_i, code_shift_i} = '0;
      {words_available_i, pkt_count_i, good_pkt_count_i, track_count_i} = '0;
      {carrier_i_i, carrier_q_i, sample_data_i, sample_valid_i, link_status_i} = '0;
      rng_state = 32'h5d06;
      {key_test, model_valid, key_left} = '0;
      {stb_errors, ready_errors, led_errors, hex_errors, other_errors} = '0;
      repeat (10) begin
         @(negedge clk_16_8);
         drive_inputs(); // Live inputs that reset has to mask
      end
      reset_i = 1'b0;
      // Periodic strobes with the key released and the first one counted from reset
      for (int i = 0; i < 3; i++) begin
         wait_strobe(interval);
         if (interval != `GPS_SAMPLE_DIV_RELOAD + 1) begin
            $display("ERROR strobe_interval expected 0x%h got 0x%h",
                     `GPS_SAMPLE_DIV_RELOAD + 1, interval);
            stb_errors++;
         end
      end
      key_test = 1'b1;
      repeat (4000) begin
         @(negedge clk_16_8);
         drive_inputs();
      end
      if (step_cnt == 0 || cs_views == 0 || value_views == 0) begin
         $display("Stimulus missed a step strobe, the code-shift view or the value view");
         other_errors++;
      end
      $display("Errors: strobe %0d, ready %0d, led %0d, hex %0d, other %0d",
               stb_errors, ready_errors, led_errors, hex_errors, other_errors);
      if (stb_errors + ready_errors + led_errors + hex_errors + other_errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== src/gps_board_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gps_board_defs.svh"

module gps_board_top (
   input  logic                       clk_16_8,
   input  logic                       reset_i,
   input  logic [`GPS_SW_W-1:0]       sw_i,
   input  logic                       step_key_n_i,     // Manual step key, active low
   input  logic                       tracking_ready_i, // One-cycle pulse from tracking
   input  gps_board_pkg::acc_t        prompt_i_i,
   input  gps_board_pkg::acc_t        prompt_q_i,
   input  gps_board_pkg::acc_t        accum_i_i,
   input  gps_board_pkg::acc_t        accum_q_i,
   input  gps_board_pkg::code_shift_t code_shift_i,
   input  gps_board_pkg::pkt_cnt_t    words_available_i,
   input  gps_board_pkg::pkt_cnt_t    pkt_count_i,
   input  gps_board_pkg::pkt_cnt_t    good_pkt_count_i,
   input  gps_board_pkg::track_cnt_t  track_count_i,
   input  gps_board_pkg::carrier_t    carrier_i_i,
   input  gps_board_pkg::carrier_t    carrier_q_i,
   input  gps_board_pkg::sample_t     sample_data_i,
   input  logic                       sample_valid_i,
   input  logic                       link_status_i,
   output logic                       sample_stb_o,     // To the sample feed
   output gps_board_pkg::ledr_t       ledr_o,
   output gps_board_pkg::ledg_t       ledg_o,
   output gps_board_pkg::seg7_t       hex0_o,
   output gps_board_pkg::seg7_t       hex1_o,
   output gps_board_pkg::seg7_t       hex2_o,
   output gps_board_pkg::seg7_t       hex3_o,
   output gps_board_pkg::seg7_t       hex4_o,
   output gps_board_pkg::seg7_t       hex5_o,
   output gps_board_pkg::seg7_t       hex6_o,
   output gps_board_pkg::seg7_t       hex7_o
);
   import gps_board_pkg::*;

   logic ready_flag; // Stretched tracking-ready

   // Sample strobe, periodic plus manual step
   sample_strobe_gen i_strobe (
      .clk_16_8     (clk_16_8),
      .reset_i      (reset_i),
      .step_key_n_i (step_key_n_i),
      .sample_stb_o (sample_stb_o)
   );

   ready_stretcher i_ready (
      .clk_16_8         (clk_16_8),
      .reset_i          (reset_i),
      .tracking_ready_i (tracking_ready_i),
      .ready_flag_o     (ready_flag)
   );

   // LEDs and seven-segment digits
   display_control i_display (
      .clk_16_8          (clk_16_8),
      .reset_i           (reset_i),
      .sw_i              (sw_i),
      .ready_flag_i      (ready_flag),
      .prompt_i_i        (prompt_i_i),
      .prompt_q_i        (prompt_q_i),
      .accum_i_i         (accum_i_i),
      .accum_q_i         (accum_q_i),
      .code_shift_i      (code_shift_i),
      .words_available_i (words_available_i),
      .pkt_count_i       (pkt_count_i),
      .good_pkt_count_i  (good_pkt_count_i),
      .track_count_i     (track_count_i),
      .carrier_i_i       (carrier_i_i),
      .carrier_q_i       (carrier_q_i),
      .sample_data_i     (sample_data_i),
      .sample_valid_i    (sample_valid_i),
      .link_status_i     (link_status_i),
      .ledr_o            (ledr_o),
      .ledg_o            (ledg_o),
      .hex0_o            (hex0_o),
      .hex1_o            (hex1_o),
      .hex2_o            (hex2_o),
      .hex3_o            (hex3_o),
      .hex4_o            (hex4_o),
      .hex5_o            (hex5_o),
      .hex6_o            (hex6_o),
      .hex7_o            (hex7_o)
   );

endmodule

`default_nettype wire

// ==== src/ready_stretcher.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gps_board_defs.svh"

module ready_stretcher (
   input  logic clk_16_8,
   input  logic reset_i,
   input  logic tracking_ready_i, // Single-cycle pulse
   output logic ready_flag_o
);
   import gps_board_pkg::*;

   hold_cnt_t hold_cnt;

   always_ff @(posedge clk_16_8) begin
      if (reset_i) begin
         hold_cnt     <= '0;
         ready_flag_o <= 1'b0;
      end else if (tracking_ready_i) begin
         hold_cnt     <= hold_cnt_t'(`GPS_READY_HOLD); // Retrigger restarts the hold
         ready_flag_o <= 1'b1;
      end else if (hold_cnt == '0) begin
         ready_flag_o <= 1'b0; // Hold expired
      end else begin
         hold_cnt <= hold_cnt - 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== src/sample_strobe_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gps_board_defs.svh"

module sample_strobe_gen (
   input  logic clk_16_8,
   input  logic reset_i,
   input  logic step_key_n_i, // Asynchronous, active low
   output logic sample_stb_o
);
   import gps_board_pkg::*;

   div_cnt_t div_cnt;
   logic     div_zero;
   logic     key_sync1;
   logic     key_sync2;
   logic     key_prev;
   logic     step_q;

   assign div_zero = (div_cnt == '0);

   // Down counter sets the receiver sample rate
   always_ff @(posedge clk_16_8) begin
      if (reset_i) begin
         div_cnt <= div_cnt_t'(`GPS_SAMPLE_DIV_RELOAD);
      end else if (div_zero) begin
         div_cnt <= div_cnt_t'(`GPS_SAMPLE_DIV_RELOAD); // Reload on the strobe cycle
      end else begin
         div_cnt <= div_cnt - 1'b1;
      end
   end

   // Two-flop synchronizer and falling-edge detect on the step key.
   // Flops come out of reset at the released level so no edge is seen.
   always_ff @(posedge clk_16_8) begin
      if (reset_i) begin
         key_sync1 <= 1'b1;
         key_sync2 <= 1'b1;
         key_prev  <= 1'b1;
         step_q    <= 1'b0;
      end else begin
         key_sync1 <= step_key_n_i;
         key_sync2 <= key_sync1;
         key_prev  <= key_sync2;
         step_q    <= key_prev & ~key_sync2; // Press seen
      end
   end

   // Periodic and manual strobes merge into one pulse
   always_ff @(posedge clk_16_8) begin
      if (reset_i) begin
         sample_stb_o <= 1'b0;
      end else begin
         sample_stb_o <= div_zero | step_q;
      end
   end

endmodule

`default_nettype wire

// ==== display/display_control.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gps_board_defs.svh"

module display_control (
   input  logic                       clk_16_8,
   input  logic                       reset_i,
   input  logic [`GPS_SW_W-1:0]       sw_i,
   input  logic                       ready_flag_i,
   input  gps_board_pkg::acc_t        prompt_i_i,
   input  gps_board_pkg::acc_t        prompt_q_i,
   input  gps_board_pkg::acc_t        accum_i_i,
   input  gps_board_pkg::acc_t        accum_q_i,
   input  gps_board_pkg::code_shift_t code_shift_i,
   input  gps_board_pkg::pkt_cnt_t    words_available_i,
   input  gps_board_pkg::pkt_cnt_t    pkt_count_i,
   input  gps_board_pkg::pkt_cnt_t    good_pkt_count_i,
   input  gps_board_pkg::track_cnt_t  track_count_i,
   input  gps_board_pkg::carrier_t    carrier_i_i,
   input  gps_board_pkg::carrier_t    carrier_q_i,
   input  gps_board_pkg::sample_t     sample_data_i,
   input  logic                       sample_valid_i,
   input  logic                       link_status_i,
   output gps_board_pkg::ledr_t       ledr_o,
   output gps_board_pkg::ledg_t       ledg_o,
   output gps_board_pkg::seg7_t       hex0_o,
   output gps_board_pkg::seg7_t       hex1_o,
   output gps_board_pkg::seg7_t       hex2_o,
   output gps_board_pkg::seg7_t       hex3_o,
   output gps_board_pkg::seg7_t       hex4_o,
   output gps_board_pkg::seg7_t       hex5_o,
   output gps_board_pkg::seg7_t       hex6_o,
   output gps_board_pkg::seg7_t       hex7_o
);
   import gps_board_pkg::*;

   logic                       disp_acc;
   logic                       disp_q;
   logic                       disp_cs;
   logic                       disp_words;
   logic                       disp_track;
   logic                       disp_pkt;
   logic                       disp_pkt_good;
   logic                       disp_carrier_q;
   acc_t                       sel_value;
   ledr_t                      ledr_d;
   ledg_t                      ledg_d;
   nibble_t                    nib_d [`GPS_NUM_DIGITS];
   logic [`GPS_NUM_DIGITS-1:0] en_d;
   nibble_t                    nib_q [`GPS_NUM_DIGITS];
   logic [`GPS_NUM_DIGITS-1:0] en_q;
   seg7_t                      seg [`GPS_NUM_DIGITS];

   // Switch fields
   assign disp_acc       = sw_i[17]; // Accumulator instead of prompt
   assign disp_q         = sw_i[16]; // Q arm instead of I
   assign disp_cs        = sw_i[15]; // Code shift on the digits
   assign disp_words     = sw_i[14];
   assign disp_track     = sw_i[13];
   assign disp_pkt       = sw_i[12];
   assign disp_pkt_good  = sw_i[11];
   assign disp_carrier_q = sw_i[10];

   assign sel_value = disp_acc ? (disp_q ? accum_q_i : accum_i_i) :
                                 (disp_q ? prompt_q_i : prompt_i_i);

   always_comb begin
      if (disp_words) begin
         ledr_d = ledr_t'(words_available_i);
      end else if (disp_track) begin
         ledr_d = ledr_t'(track_count_i);
      end else if (disp_pkt) begin
         ledr_d = disp_pkt_good ? ledr_t'(good_pkt_count_i) : ledr_t'(pkt_count_i);
      end else begin
         ledr_d = ledr_t'(sel_value);
      end
   end

   assign ledg_d = {link_status_i,
                    disp_carrier_q ? carrier_q_i : carrier_i_i,
                    sample_data_i,
                    sample_valid_i,
                    ready_flag_i};

   // Digit contents, upper three digits stay dark
   always_comb begin
      nib_d    = '{default: '0};
      en_d     = '0;
      nib_d[4] = {2'b00, sel_value[17:16]};
      en_d[4]  = ~disp_cs;
      en_d[3:0] = 4'hf;
      if (disp_cs) begin
         nib_d[3] = {1'b0, code_shift_i[14:12]};
         nib_d[2] = code_shift_i[11:8];
         nib_d[1] = code_shift_i[7:4];
         nib_d[0] = code_shift_i[3:0];
      end else begin
         nib_d[3] = sel_value[15:12];
         nib_d[2] = sel_value[11:8];
         nib_d[1] = sel_value[7:4];
         nib_d[0] = sel_value[3:0];
      end
   end

   always_ff @(posedge clk_16_8) begin
      if (reset_i) begin
         ledr_o <= '0;
         ledg_o <= '0;
         en_q   <= '0; // All digits blank
      end else begin
         ledr_o <= ledr_d;
         ledg_o <= ledg_d;
         en_q   <= en_d;
      end
   end

   always_ff @(posedge clk_16_8) begin
      nib_q <= nib_d;
   end

   for (genvar d = 0; d < `GPS_NUM_DIGITS; d++) begin : g_digit
      seg7_encoder i_seg (
         .digit_i  (nib_q[d]),
         .enable_i (en_q[d]),
         .seg_o    (seg[d])
      );
   end

   assign hex0_o = seg[0];
   assign hex1_o = seg[1];
   assign hex2_o = seg[2];
   assign hex3_o = seg[3];
   assign hex4_o = seg[4];
   assign hex5_o = seg[5];
   assign hex6_o = seg[6];
   assign hex7_o = seg[7];

endmodule

`default_nettype wire

// ==== display/seg7_encoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module seg7_encoder (
   input  gps_board_pkg::nibble_t digit_i,
   input  logic                   enable_i, // Low blanks the digit
   output gps_board_pkg::seg7_t   seg_o
);
   import gps_board_pkg::*;

   seg7_t glyph;

   // Active low, segment g in bit 6 down to segment a in bit 0
   always_comb begin
      case (digit_i)
         4'h0:    glyph = 7'h40;
         4'h1:    glyph = 7'h79;
         4'h2:    glyph = 7'h24;
         4'h3:    glyph = 7'h30;
         4'h4:    glyph = 7'h19;
         4'h5:    glyph = 7'h12;
         4'h6:    glyph = 7'h02;
         4'h7:    glyph = 7'h78;
         4'h8:    glyph = 7'h00;
         4'h9:    glyph = 7'h10;
         4'ha:    glyph = 7'h08;
         4'hb:    glyph = 7'h03; // Lower case b
         4'hc:    glyph = 7'h46;
         4'hd:    glyph = 7'h21; // Lower case d
         4'he:    glyph = 7'h06;
         default: glyph = 7'h0e;
      endcase
   end

   assign seg_o = enable_i ? glyph : '1;

endmodule

`default_nettype wire

// ==== common/gps_board_pkg.sv ====
`default_nettype none

`include "gps_board_defs.svh"

package gps_board_pkg;

   // Receiver core results
   typedef logic [`GPS_ACC_W-1:0]       acc_t;        // Prompt or accumulator
   typedef logic [`GPS_CS_W-1:0]        code_shift_t; // Code phase shift
   typedef logic [`GPS_CNT_W-1:0]       pkt_cnt_t;    // Word or packet count
   typedef logic [`GPS_TRACK_CNT_W-1:0] track_cnt_t;  // Tracking counter

   // Sample feed
   typedef logic [`GPS_SAMPLE_W-1:0]    carrier_t;    // Carrier sample
   typedef logic [`GPS_SAMPLE_W-1:0]    sample_t;     // Raw sample

   // Display
   typedef logic [3:0]                  nibble_t;     // One hex digit
   typedef logic [6:0]                  seg7_t;       // Active low, bit 0 is segment a
   typedef logic [`GPS_LEDR_W-1:0]      ledr_t;       // Red LED bank
   typedef logic [`GPS_LEDG_W-1:0]      ledg_t;       // Green LED bank

   // Internal counters
   typedef logic [`GPS_HOLD_W-1:0]      hold_cnt_t;   // Ready hold counter
   typedef logic [`GPS_DIV_W-1:0]       div_cnt_t;    // Sample divider

endpackage

`default_nettype wire

// ==== common/gps_board_defs.svh ====
`ifndef GPS_BOARD_DEFS_SVH
`define GPS_BOARD_DEFS_SVH

// Sample rate divider, one strobe every reload+1 clocks
`define GPS_SAMPLE_DIV_RELOAD 168
`define GPS_DIV_W             9

// Tracking-ready hold, flag stays up for reload+1 clocks
`define GPS_READY_HOLD        7
`define GPS_HOLD_W            4

// Receiver quantity widths
`define GPS_ACC_W             18
`define GPS_CS_W              15
`define GPS_CNT_W             9
`define GPS_TRACK_CNT_W       4
`define GPS_SAMPLE_W          3

// Board display widths
`define GPS_SW_W              18
`define GPS_LEDR_W            18
`define GPS_LEDG_W            9
`define GPS_NUM_DIGITS        8

`endif
